//--- verilog/common.sv
package common;

        localparam int xlen = 32;
        localparam int reg_addr_w = 5;
        localparam int shamt_w = 5;

        localparam logic [6:0] m_type_funct7 = 7'b000_0001; // mul/div group.
        localparam logic [6:0] alt_funct7 = 7'b010_0000;    // sub and sra.

        // major opcodes, bits 6:0 of the instruction.
        typedef enum logic [6:0] {
                OP      = 7'b011_0011,
                OP_IMM  = 7'b001_0011,
                U_LUI   = 7'b011_0111,
                U_AUIPC = 7'b001_0111,
                J_JAL   = 7'b110_1111,
                JALR    = 7'b110_0111,
                OTHER   = 7'b000_0000
        } instruction_format_type;

        typedef enum logic [4:0] {
                ADD,
                SUB,
                SLL,
                SRL,
                SRA,
                XOR,
                OR,
                AND,
                SLT,
                SLTU,
                LUI,
                AUIPC,
                LINK,
                DIV,
                DIVU,
                REM,
                REMU
        } alu_operation_type;

        // r-type layout; other formats reuse the same bit positions.
        typedef struct packed {
                logic [6:0]            funct7;
                logic [reg_addr_w-1:0] rs2;
                logic [reg_addr_w-1:0] rs1;
                logic [2:0]            funct3;
                logic [reg_addr_w-1:0] rd;
                logic [6:0]            opcode;
        } instr_fields_type;

        typedef struct packed {
                logic [31:0]      instr;
                logic [xlen-1:0]  pc;
                logic [xlen-1:0]  rs1_val;
                logic [xlen-1:0]  rs2_val;
        } exec_in_type;

        typedef struct packed {
                instruction_format_type opcode;
                logic [2:0]             funct3;
                logic [6:0]             funct7;
                logic [reg_addr_w-1:0]  rd;
                logic [xlen-1:0]        imm;
                logic [xlen-1:0]        pc;
                logic [xlen-1:0]        rs1_val;
                logic [xlen-1:0]        rs2_val;
        } decoded_type;

        typedef struct packed {
                logic [reg_addr_w-1:0] rd;
                logic [xlen-1:0]       result;
        } exec_out_type;

endpackage

//--- verilog/instr_decode.sv
module instr_decode (
        input  logic                 clk,
        input  logic                 arst_n,
        input  logic                 in_valid,
        input  common::exec_in_type  in_data,
        output logic                 dec_valid,
        output common::decoded_type  dec
);

        common::instr_fields_type        fields;
        common::instruction_format_type  opcode;
        common::decoded_type             dec_next;
        logic [common::xlen-1:0]         imm_i;
        logic [common::xlen-1:0]         imm_u;
        logic [common::xlen-1:0]         imm;
        logic [6:0]                      funct7;
        logic                            is_shift;

        assign fields = in_data.instr;

        assign imm_i = {{(common::xlen-12){fields.funct7[6]}}, fields.funct7, fields.rs2};
        assign imm_u = {fields.funct7, fields.rs2, fields.rs1, fields.funct3, 12'b0};

        always_comb
        begin
                case (fields.opcode)
                        common::OP:      opcode = common::OP;
                        common::OP_IMM:  opcode = common::OP_IMM;
                        common::U_LUI:   opcode = common::U_LUI;
                        common::U_AUIPC: opcode = common::U_AUIPC;
                        common::J_JAL:   opcode = common::J_JAL;
                        common::JALR:    opcode = common::JALR;
                        default:         opcode = common::OTHER; // loads, stores, branches.
                endcase
        end

        always_comb
        begin
                case (opcode)
                        common::OP_IMM, common::JALR:   imm = imm_i;
                        common::U_LUI, common::U_AUIPC: imm = imm_u;
                        default:                        imm = '0;
                endcase
        end

        // slli/srli/srai keep the shift type in bits 31:25.
        assign is_shift = (fields.funct3 == 3'b001) || (fields.funct3 == 3'b101);

        always_comb
        begin
                funct7 = '0;
                if (opcode == common::OP)
                        funct7 = fields.funct7;
                else if (opcode == common::OP_IMM && is_shift)
                        funct7 = fields.funct7;
        end

        always_comb
        begin
                dec_next.opcode  = opcode;
                dec_next.funct3  = fields.funct3;
                dec_next.funct7  = funct7;
                dec_next.rd      = fields.rd;
                dec_next.imm     = imm;
                dec_next.pc      = in_data.pc;
                dec_next.rs1_val = in_data.rs1_val;
                dec_next.rs2_val = in_data.rs2_val;
        end

        always_ff @(posedge clk or negedge arst_n)
        begin
                if (!arst_n)
                begin
                        dec_valid <= 1'b0;
                        dec       <= '0;
                end
                else
                begin
                        dec_valid <= in_valid;
                        if (in_valid)
                                dec <= dec_next;
                end
        end

endmodule

//--- verilog/alu_ctrl.sv
module alu_ctrl (
        input  logic                            clk,
        input  common::instruction_format_type  opcode,
        input  logic [2:0]                      funct3,
        input  logic [6:0]                      funct7,
        output common::alu_operation_type       op
);

        logic is_op;
        logic is_alt;
        logic is_m;

        assign is_op  = (opcode == common::OP);
        assign is_alt = (funct7 == common::alt_funct7);
        assign is_m   = is_op && (funct7 == common::m_type_funct7); // no m ops on immediates.

        always_comb
        begin
                op = common::ADD; // also covers unknown opcodes.

                if (opcode == common::OP || opcode == common::OP_IMM)
                begin
                        case (funct3)
                                3'b000:
                                        op = (is_op && is_alt) ? common::SUB : common::ADD;
                                3'b001:
                                        op = common::SLL;
                                3'b010:
                                        op = common::SLT;
                                3'b011:
                                        op = common::SLTU;
                                3'b100:
                                        op = is_m ? common::DIV : common::XOR;
                                3'b101:
                                begin
                                        if (is_m)
                                                op = common::DIVU;
                                        else if (is_alt)
                                                op = common::SRA;
                                        else
                                                op = common::SRL;
                                end
                                3'b110:
                                        op = is_m ? common::REM : common::OR;
                                default:
                                        op = is_m ? common::REMU : common::AND;
                        endcase
                end
                else if (opcode == common::U_LUI)
                        op = common::LUI;
                else if (opcode == common::U_AUIPC)
                        op = common::AUIPC;
                else if (opcode == common::J_JAL || opcode == common::JALR)
                        op = common::LINK; // rd gets pc + 4.
        end

        op_known: assert property (@(posedge clk) !$isunknown(op))
                else $error("alu_ctrl: operation is unknown");

endmodule

//--- verilog/alu.sv
module alu (
        input  logic                       clk,
        input  logic                       arst_n,
        input  logic                       dec_valid,
        input  common::decoded_type        dec,
        input  common::alu_operation_type  op,
        output common::exec_out_type       res
);

        logic [common::xlen-1:0]    a;
        logic [common::xlen-1:0]    b;
        logic [common::shamt_w-1:0] shamt;
        logic                       div_zero;
        logic                       div_ovf;
        logic [common::xlen-1:0]    div_s_safe;
        logic [common::xlen-1:0]    div_u_safe;
        logic [common::xlen-1:0]    quot_s;
        logic [common::xlen-1:0]    rem_s;
        logic [common::xlen-1:0]    quot_u;
        logic [common::xlen-1:0]    rem_u;
        logic [common::xlen-1:0]    result;
        logic [common::xlen:0]      diff;
        logic                       lt_s;
        logic                       lt_u;

        assign a     = dec.rs1_val;
        assign b     = (dec.opcode == common::OP) ? dec.rs2_val : dec.imm;
        assign shamt = b[common::shamt_w-1:0];

        assign div_zero = (b == '0);
        assign div_ovf  = (a == {1'b1, {(common::xlen-1){1'b0}}}) && (b == '1);

        // divisor forced to 1 in the special cases so the quotient stays defined.
        assign div_s_safe = (div_zero || div_ovf) ? 1 : b;
        assign div_u_safe = div_zero ? 1 : b;

        assign quot_s = $signed(a) / $signed(div_s_safe);
        assign rem_s  = $signed(a) % $signed(div_s_safe);
        assign quot_u = a / div_u_safe;
        assign rem_u  = a % div_u_safe;

        always_comb
        begin
                case (op)
                        common::SUB:   result = a - b;
                        common::SLL:   result = a << shamt;
                        common::SRL:   result = a >> shamt;
                        common::SRA:   result = $signed(a) >>> shamt;
                        common::XOR:   result = a ^ b;
                        common::OR:    result = a | b;
                        common::AND:   result = a & b;
                        common::SLT:   result = {{(common::xlen-1){1'b0}}, $signed(a) < $signed(b)};
                        common::SLTU:  result = {{(common::xlen-1){1'b0}}, a < b};
                        common::LUI:   result = dec.imm;
                        common::AUIPC: result = dec.pc + dec.imm;
                        common::LINK:  result = dec.pc + 4;
                        common::DIV:
                        begin
                                if (div_zero)
                                        result = '1;
                                else if (div_ovf)
                                        result = a;
                                else
                                        result = quot_s;
                        end
                        common::DIVU:  result = div_zero ? '1 : quot_u;
                        common::REM:
                        begin
                                if (div_zero)
                                        result = a;
                                else if (div_ovf)
                                        result = '0;
                                else
                                        result = rem_s;
                        end
                        common::REMU:  result = div_zero ? a : rem_u;
                        default:       result = a + b;
                endcase
        end

        assign res.rd     = dec.rd;
        assign res.result = result;

        // compare bits taken from the borrow of a - b.
        assign diff = {1'b0, a} - {1'b0, b};
        assign lt_u = diff[common::xlen];
        assign lt_s = (a[common::xlen-1] != b[common::xlen-1]) ? a[common::xlen-1]
                                                               : diff[common::xlen-1];

        // compares write a single bit.
        cmp_is_bit: assert property (@(posedge clk) disable iff (!arst_n)
                dec_valid && (op == common::SLT || op == common::SLTU)
                |-> res.result == {{(common::xlen-1){1'b0}}, (op == common::SLT) ? lt_s : lt_u})
                else $error("alu: compare result is not the expected single bit");

endmodule

//--- verilog/exec_result.sv
module exec_result (
        input  logic                  clk,
        input  logic                  arst_n,
        input  logic                  dec_valid,
        input  common::exec_out_type  res,
        output logic                  out_valid,
        output common::exec_out_type  out_data
);

        always_ff @(posedge clk or negedge arst_n)
        begin
                if (!arst_n)
                begin
                        out_valid <= 1'b0;
                        out_data  <= '0;
                end
                else
                begin
                        out_valid <= dec_valid; // one-cycle pulse per item.
                        if (dec_valid)
                                out_data <= res;
                end
        end

        // a result leaving the stage is fully defined.
        out_known: assert property (@(posedge clk) disable iff (!arst_n)
                out_valid |-> !$isunknown(out_data))
                else $error("exec_result: output data unknown while valid");

endmodule

//--- verilog/exec_unit.sv
module exec_unit (
        input  logic                  clk,
        input  logic                  arst_n,
        input  logic                  in_valid,
        input  common::exec_in_type   in_data,
        output logic                  out_valid,
        output common::exec_out_type  out_data
);

        logic                       dec_valid;
        common::decoded_type        dec;
        common::alu_operation_type  op;
        common::exec_out_type       res;

        instr_decode instr_decode_inst (
                .clk       (clk),
                .arst_n    (arst_n),
                .in_valid  (in_valid),
                .in_data   (in_data),
                .dec_valid (dec_valid),
                .dec       (dec)
        );

        alu_ctrl alu_ctrl_inst (
                .clk    (clk),
                .opcode (dec.opcode),
                .funct3 (dec.funct3),
                .funct7 (dec.funct7),
                .op     (op)
        );

        alu alu_inst (
                .clk       (clk),
                .arst_n    (arst_n),
                .dec_valid (dec_valid),
                .dec       (dec),
                .op        (op),
                .res       (res)
        );

        exec_result exec_result_inst (
                .clk       (clk),
                .arst_n    (arst_n),
                .dec_valid (dec_valid),
                .res       (res),
                .out_valid (out_valid),
                .out_data  (out_data)
        );

endmodule

//--- sim/exec_unit_tb.sv
module exec_unit_tb;
        timeunit 1ns;
        timeprecision 1ps;

        logic                  clk;
        logic                  arst_n;
        logic                  in_valid;
        common::exec_in_type   in_data;
        logic                  out_valid;
        common::exec_out_type  out_data;

        integer seed = 32'h377c_df37;
        int     errors = 0;
        int     timeouts = 0;

        string       reg_names[10] = '{"ADD", "SUB", "SLL", "SRL", "SRA", "XOR", "OR", "AND",
                                       "SLT", "SLTU"};
        logic [2:0]  reg_f3[10] = '{3'd0, 3'd0, 3'd1, 3'd5, 3'd5, 3'd4, 3'd6, 3'd7, 3'd2, 3'd3};
        logic [9:0]  reg_alt = 10'b00_0001_0010; // sub and sra.
        logic [31:0] edges[5] = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000,
                                  32'h7fff_ffff};

        exec_unit exec_unit_inst (
                .clk       (clk),
                .arst_n    (arst_n),
                .in_valid  (in_valid),
                .in_data   (in_data),
                .out_valid (out_valid),
                .out_data  (out_data)
        );

        initial
        begin
                clk = 1'b0;
                forever #50 clk = ~clk;
        end

        function automatic logic [31:0] next_random();
                return $random(seed);
        endfunction

        // architectural division with the zero divisor and overflow cases.
        function automatic logic [31:0] ref_div(logic [31:0] a, logic [31:0] b, logic is_signed,
                                                logic want_rem);
                if (b == 32'd0)
                        return want_rem ? a : 32'hffff_ffff;
                if (is_signed && a == 32'h8000_0000 && b == 32'hffff_ffff)
                        return want_rem ? 32'd0 : a;
                if (is_signed)
                        return want_rem ? $signed(a) % $signed(b) : $signed(a) / $signed(b);
                return want_rem ? a % b : a / b;
        endfunction

        function automatic logic [31:0] ref_result(logic [31:0] instr, logic [31:0] pc,
                                                   logic [31:0] a, logic [31:0] rs2v);
                logic [6:0]  opc;
                logic [2:0]  f3;
                logic        alt;
                logic        m;
                logic [31:0] b;
                logic [31:0] r;

                opc = instr[6:0];
                f3  = instr[14:12];
                alt = (instr[31:25] == common::alt_funct7);
                m   = (opc == common::OP) && (instr[31:25] == common::m_type_funct7);
                b   = (opc == common::OP) ? rs2v : {{20{instr[31]}}, instr[31:20]};
                r   = a; // unknown opcodes give rs1 plus a zero immediate.
                if (opc == common::U_LUI)
                        r = {instr[31:12], 12'h000};
                else if (opc == common::U_AUIPC)
                        r = pc + {instr[31:12], 12'h000};
                else if (opc == common::J_JAL || opc == common::JALR)
                        r = pc + 32'd4;
                else if (m && f3[2])
                        r = ref_div(a, b, !f3[0], f3[1]);
                else if (opc == common::OP || opc == common::OP_IMM)
                begin
                        case (f3)
                                3'd0: r = (opc == common::OP && alt) ? a - b : a + b;
                                3'd1: r = a << b[4:0];
                                3'd2: r = {31'd0, $signed(a) < $signed(b)};
                                3'd3: r = {31'd0, a < b};
                                3'd4: r = a ^ b;
                                3'd5:
                                        if (alt)
                                                r = $signed(a) >>> b[4:0];
                                        else
                                                r = a >> b[4:0];
                                3'd6: r = a | b;
                                default: r = a & b;
                        endcase
                end
                return r;
        endfunction

        task automatic check_value(string what, logic [31:0] actual, logic [31:0] expected);
                if (actual !== expected)
                begin
                        errors++;
                        $display("FAILED at %0d ns: %s: got %h, expected %h", $time, what,
                                 actual, expected);
                end
        endtask

        task automatic drive_input(logic [31:0] instr, logic [31:0] pc, logic [31:0] a,
                                   logic [31:0] b);
                in_data.instr   = instr;
                in_data.pc      = pc;
                in_data.rs1_val = a;
                in_data.rs2_val = b;
                in_valid        = 1'b1;
        endtask

        // one strobe, then wait for its result and check latency, rd and value.
        task automatic run_one(string name, logic [31:0] instr, logic [31:0] pc,
                               logic [31:0] a, logic [31:0] b);
                logic [31:0] exp_result;
                int          cycles;

                exp_result = ref_result(instr, pc, a, b);
                cycles     = 0;
                @(negedge clk);
                drive_input(instr, pc, a, b);
                do
                begin
                        @(negedge clk);
                        cycles++;
                        in_valid = 1'b0;
                end
                while (!out_valid && cycles < 20);
                if (!out_valid)
                begin
                        timeouts++;
                        $display("timeout: no result appeared within 20 cycles for %s", name);
                end
                else
                begin
                        check_value({name, " latency"}, cycles, 32'd2);
                        check_value({name, " rd"}, {27'd0, out_data.rd}, {27'd0, instr[11:7]});
                        check_value(name, out_data.result, exp_result);
                end
        endtask

        task automatic test_reset_idle();
                for (int i = 0; i < 5; i++)
                begin
                        @(negedge clk);
                        check_value("idle valid", {31'd0, out_valid}, 32'd0);
                        check_value("idle result", out_data.result, 32'd0);
                end
        endtask

        task automatic test_reg_ops();
                logic [31:0] r;
                logic [31:0] a;
                logic [31:0] b;
                logic [6:0]  f7;

                for (int k = 0; k < 10; k++)
                begin
                        f7 = reg_alt[k] ? common::alt_funct7 : 7'd0;
                        for (int n = 0; n < 31; n++)
                        begin
                                r = next_random();
                                a = (n < 25) ? edges[n / 5] : next_random();
                                b = (n < 25) ? edges[n % 5] : next_random();
                                run_one(reg_names[k],
                                        {f7, 5'd2, 5'd1, reg_f3[k], r[11:7], common::OP},
                                        32'd0, a, b);
                        end
                end
        endtask

        function automatic logic [31:0] i_type(logic [11:0] imm, logic [2:0] f3, logic [4:0] rd,
                                               logic [6:0] opc);
                return {imm, 5'd1, f3, rd, opc};
        endfunction

        task automatic test_imm_ops();
                logic [31:0] r;
                logic [31:0] a;
                logic [31:0] b;
                logic [31:0] pc;
                logic [4:0]  rd;
                logic [6:0]  opi;

                opi = common::OP_IMM;
                for (int n = 0; n < 8; n++)
                begin
                        r  = next_random();
                        a  = next_random();
                        b  = next_random();
                        pc = next_random() & 32'hffff_fffc;
                        rd = r[11:7];
                        run_one("ADDI alt", i_type({common::alt_funct7, r[4:0]}, 3'd0, rd, opi),
                                pc, a, b);
                        run_one("SLTI", i_type(r[31:20], 3'd2, rd, opi), pc, a, b);
                        run_one("SLTIU", i_type(r[31:20], 3'd3, rd, opi), pc, a, b);
                        run_one("XORI", i_type(r[31:20], 3'd4, rd, opi), pc, a, b);
                        run_one("SLLI", i_type({7'd0, r[24:20]}, 3'd1, rd, opi), pc, a, b);
                        run_one("SRLI", i_type({7'd0, r[24:20]}, 3'd5, rd, opi), pc, a, b);
                        run_one("SRAI", i_type({common::alt_funct7, r[24:20]}, 3'd5, rd, opi),
                                pc, a, b);
                        run_one("LUI", {r[31:12], rd, common::U_LUI}, pc, a, b);
                        run_one("AUIPC", {r[31:12], rd, common::U_AUIPC}, pc, a, b);
                        run_one("JAL", {r[31:12], rd, common::J_JAL}, pc, a, b);
                        run_one("JALR", i_type(r[31:20], 3'd0, rd, common::JALR), pc, a, b);
                        run_one("OTHER", {r[31:7], 7'b000_0011}, pc, a, b); // a load.
                end
        endtask

        task automatic test_div();
                string       names[4] = '{"DIV", "DIVU", "REM", "REMU"};
                logic [31:0] instr;
                logic [31:0] r;

                for (int k = 0; k < 4; k++)
                begin
                        r     = next_random();
                        instr = {common::m_type_funct7, 5'd2, 5'd1, 3'(4 + k), r[11:7], common::OP};
                        for (int n = 0; n < 8; n++)
                                run_one(names[k], instr, 32'd0, next_random(),
                                        next_random() >> (n * 4));
                        run_one({names[k], " by zero"}, instr, 32'd0, next_random(), 32'd0);
                        run_one({names[k], " overflow"}, instr, 32'd0, 32'h8000_0000,
                                32'hffff_ffff);
                end
        endtask

        // 16 strobes in a row; results must come out on 16 consecutive cycles.
        task automatic test_burst();
                logic [31:0] instr[16];
                logic [31:0] a[16];
                logic [31:0] b[16];
                logic [31:0] r;
                int          received;
                int          cycle;

                for (int i = 0; i < 16; i++)
                begin
                        r    = next_random();
                        a[i] = next_random();
                        b[i] = next_random();
                        case (i % 6)
                                0: instr[i] = {7'd0, 10'd0, 3'd0, 5'(i + 1), common::OP};
                                1: instr[i] = {common::alt_funct7, 10'd0, 3'd0, 5'(i + 1),
                                               common::OP};
                                2: instr[i] = {common::alt_funct7, 10'd0, 3'd5, 5'(i + 1),
                                               common::OP};
                                3: instr[i] = {common::m_type_funct7, 10'd0, 3'd5, 5'(i + 1),
                                               common::OP};
                                4: instr[i] = {r[31:12], 5'(i + 1), common::U_LUI};
                                default: instr[i] = {r[31:12], 5'(i + 1), 7'b110_0011}; // a branch.
                        endcase
                end
                received = 0;
                cycle    = 0;
                @(negedge clk);
                while (received < 16 && cycle < 36)
                begin
                        check_value("burst valid", {31'd0, out_valid},
                                    (cycle >= 2 && cycle < 18) ? 32'd1 : 32'd0);
                        if (out_valid)
                        begin
                                check_value("burst rd", {27'd0, out_data.rd},
                                            {27'd0, instr[received][11:7]});
                                check_value("burst result", out_data.result,
                                            ref_result(instr[received], 32'd0, a[received],
                                                       b[received]));
                                received++;
                        end
                        if (cycle < 16)
                                drive_input(instr[cycle], 32'd0, a[cycle], b[cycle]);
                        else
                                in_valid = 1'b0;
                        cycle++;
                        @(negedge clk);
                end
                in_valid = 1'b0;
                if (received < 16)
                begin
                        timeouts++;
                        $display("timeout: only %0d of 16 burst results appeared", received);
                end
        endtask

        initial
        begin
                arst_n   = 1'b0;
                in_valid = 1'b0;
                in_data  = '0;
                repeat (4) @(posedge clk);
                @(negedge clk);
                arst_n = 1'b1;
                test_reset_idle();
                test_reg_ops();
                test_imm_ops();
                test_div();
                test_burst();
                @(negedge clk);
                $display("errors: %0d, timeouts: %0d", errors, timeouts);
                if (errors == 0 && timeouts == 0)
                        $display("Regression passed");
                else
                        $display("Regression failed");
                $finish;
        end

endmodule

//--- vlog.f
verilog/common.sv
verilog/instr_decode.sv
verilog/alu_ctrl.sv
verilog/alu.sv
verilog/exec_result.sv
verilog/exec_unit.sv
sim/exec_unit_tb.sv

//--- Makefile
VERILATOR  ?= verilator
FLAGS      = --timing --assert
SIM_FLAGS  = --binary -j 0
TOP        = exec_unit_tb
FILELIST   = vlog.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
